// File: compile.f
dsp_seq_pkg.sv
dsp_seq_decode.sv
dsp_seq_flags.sv
dsp_seq_rom_aau.sv
dsp_seq_top.sv
tb_dsp_seq_sva.sv
tb_dsp_seq.sv

// File: dsp_seq_decode.sv
//////////////////////////////////////////////////////////////////////
// Sequencer instruction decoder
// One-hot control strobes gated by cen, interrupt shadow state
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module dsp_seq_decode (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             cen,
    input  logic                             ext_irq,
    input  dsp_seq_pkg::instr_t              instr,       // Word at PC
    input  logic                             con_result,  // From flags
    output logic                             goto_ja,
    output logic                             call_ja,
    output logic                             goto_b,
    output logic                             icall,
    output logic                             post_inc,
    output logic                             pc_halt,
    output logic                             irq_take,
    output logic                             setf,
    output logic [dsp_seq_pkg::FIELD_W-1:0]  i_field,
    output logic [dsp_seq_pkg::FLAG_W-1:0]   flag_val,
    output logic [dsp_seq_pkg::COND_W-1:0]   cond,
    output logic                             shadow,      // Not in service
    output logic                             in_irq
);

    logic [dsp_seq_pkg::OP_W-1:0] opcode;
    logic                         exec;   // Instruction runs on this edge
    logic                         iret;

    assign opcode = instr.ja_fmt.opcode;

    // Single shadow level, no nesting
    assign irq_take = cen && ext_irq && !in_irq;
    assign exec     = cen && !irq_take;   // Taken IRQ drops the word

    assign i_field  = instr.ja_fmt.field;
    assign flag_val = instr.ja_fmt.field[dsp_seq_pkg::FLAG_W-1:0];
    assign cond     = instr.br_fmt.cond;  // Only meaningful for CGOTO_B

    always_comb begin
        goto_ja  = 1'b0;
        call_ja  = 1'b0;
        goto_b   = 1'b0;
        icall    = 1'b0;
        post_inc = 1'b0;
        pc_halt  = 1'b0;
        setf     = 1'b0;
        if (exec) begin
            case (opcode)
                dsp_seq_pkg::OP_NOP:     ;
                dsp_seq_pkg::OP_GOTO_JA: goto_ja  = 1'b1;
                dsp_seq_pkg::OP_CALL_JA: call_ja  = 1'b1;
                dsp_seq_pkg::OP_GOTO_B:  goto_b   = 1'b1;
                dsp_seq_pkg::OP_CGOTO_B: goto_b   = con_result; // Untaken falls through
                dsp_seq_pkg::OP_ICALL:   icall    = 1'b1;
                dsp_seq_pkg::OP_PT_ADD:  post_inc = 1'b1;
                dsp_seq_pkg::OP_SETF:    setf     = 1'b1;
                dsp_seq_pkg::OP_HALT:    pc_halt  = 1'b1;
                default:                 ;   // Spare opcodes
            endcase
        end
    end

    // Branch view of the same word
    assign iret = goto_b && (instr.br_fmt.bsel == dsp_seq_pkg::B_IRET);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_irq <= 1'b0;
        end else if (irq_take) begin
            in_irq <= 1'b1;     // Enter service
        end else if (iret) begin
            in_irq <= 1'b0;     // Back to normal flow
        end
    end

    assign shadow = !in_irq;

endmodule

// File: dsp_seq_flags.sv
//////////////////////////////////////////////////////////////////////
// Sequencer status flags
// Flag register and condition code evaluation
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module dsp_seq_flags (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cen,
    input  logic                            setf,
    input  logic [dsp_seq_pkg::FLAG_W-1:0]  flag_val,
    input  logic [dsp_seq_pkg::COND_W-1:0]  cond,
    output logic                            con_result
);

    logic [dsp_seq_pkg::FLAG_W-1:0] flags;
    logic [dsp_seq_pkg::FSEL_W-1:0] fsel;
    logic                           sel_flag;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags <= '0;
        end else if (cen && setf) begin
            flags <= flag_val;    // Whole register at once
        end
    end

    // Flag pick, optional inversion, always override
    assign fsel     = cond[dsp_seq_pkg::FSEL_W-1:0];
    assign sel_flag = flags[fsel];

    assign con_result = cond[dsp_seq_pkg::COND_ALWAYS] ||
                        (sel_flag ^ cond[dsp_seq_pkg::COND_INV]);

endmodule

// File: dsp_seq_pkg.sv
//////////////////////////////////////////////////////////////////////
// Program sequencer shared definitions
// Address, field and flag widths, opcodes and branch subcodes
// Interrupt vectors, condition code bits, instruction word union
//////////////////////////////////////////////////////////////////////
package dsp_seq_pkg;

    localparam int ADDR_W  = 16;               // Program address
    localparam int FIELD_W = 12;               // Jump or immediate field
    localparam int FLAG_W  = 4;                // Status flags
    localparam int FSEL_W  = $clog2(FLAG_W);   // Flag select in cond
    localparam int OP_W    = 4;                // Opcode, bits 15..12
    localparam int BSEL_W  = 3;                // Branch subcode, bits 10..8
    localparam int COND_W  = 4;                // Condition code, bits 3..0

    // Opcodes, anything else runs as a NOP
    localparam logic [OP_W-1:0] OP_NOP     = 4'h0;
    localparam logic [OP_W-1:0] OP_GOTO_JA = 4'h1;   // In-page goto
    localparam logic [OP_W-1:0] OP_CALL_JA = 4'h2;   // In-page call
    localparam logic [OP_W-1:0] OP_GOTO_B  = 4'h3;   // Branch by subcode
    localparam logic [OP_W-1:0] OP_CGOTO_B = 4'h4;   // Conditional branch
    localparam logic [OP_W-1:0] OP_ICALL   = 4'h5;   // Software interrupt
    localparam logic [OP_W-1:0] OP_PT_ADD  = 4'h6;   // PT post-increment
    localparam logic [OP_W-1:0] OP_SETF    = 4'h7;   // Load flags
    localparam logic [OP_W-1:0] OP_HALT    = 4'h8;

    // Branch subcodes, 4 to 7 unused
    localparam logic [BSEL_W-1:0] B_RET     = 3'd0;
    localparam logic [BSEL_W-1:0] B_IRET    = 3'd1;
    localparam logic [BSEL_W-1:0] B_GOTO_PT = 3'd2;
    localparam logic [BSEL_W-1:0] B_CALL_PT = 3'd3;

    // Condition code bit positions
    // Low FSEL_W bits pick the flag
    localparam int COND_INV    = 2;   // Invert picked flag
    localparam int COND_ALWAYS = 3;   // Always true

    localparam logic [ADDR_W-1:0] ICALL_VEC = 16'd1;
    localparam logic [ADDR_W-1:0] IRQ_VEC   = 16'd0;

    // Jump and immediate format
    typedef struct packed {
        logic [OP_W-1:0]    opcode;
        logic [FIELD_W-1:0] field;    // Page address, PT step or flags
    } ja_fmt_t;

    // Branch format
    typedef struct packed {
        logic [OP_W-1:0]   opcode;
        logic              rsv_hi;
        logic [BSEL_W-1:0] bsel;
        logic [3:0]        rsv_lo;
        logic [COND_W-1:0] cond;
    } br_fmt_t;

    // One ROM word, two readings picked by opcode
    typedef union packed {
        ja_fmt_t ja_fmt;
        br_fmt_t br_fmt;
    } instr_t;

endpackage

// File: dsp_seq_rom_aau.sv
//////////////////////////////////////////////////////////////////////
// ROM address arithmetic unit
// PC, PR, PI and PT registers, next program address select
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module dsp_seq_rom_aau (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             cen,
    input  logic                             goto_ja,
    input  logic                             goto_b,
    input  logic                             call_ja,
    input  logic                             icall,
    input  logic                             post_inc,
    input  logic                             pc_halt,
    input  logic                             ext_irq,   // Taken interrupt
    input  logic [dsp_seq_pkg::FIELD_W-1:0]  i_field,
    input  logic                             shadow,
    output logic [dsp_seq_pkg::ADDR_W-1:0]   rom_addr
);

    logic [dsp_seq_pkg::ADDR_W-1:0] pc;       // Program counter
    logic [dsp_seq_pkg::ADDR_W-1:0] pr;       // Return address
    logic [dsp_seq_pkg::ADDR_W-1:0] pi;       // Interrupt return
    logic [dsp_seq_pkg::ADDR_W-1:0] pt;       // Table pointer
    logic [dsp_seq_pkg::ADDR_W-1:0] pc_inc;
    logic [dsp_seq_pkg::ADDR_W-1:0] i_ext;
    logic [dsp_seq_pkg::ADDR_W-1:0] pc_nxt;
    logic [dsp_seq_pkg::BSEL_W-1:0] bsel;
    logic                           ret;
    logic                           iret;
    logic                           goto_pt;
    logic                           call_pt;

    assign pc_inc = pc + 1'b1;
    assign i_ext  = {{(dsp_seq_pkg::ADDR_W - dsp_seq_pkg::FIELD_W){i_field[dsp_seq_pkg::FIELD_W-1]}},
                     i_field};   // Signed PT step

    // Subcode sits in field bits 10..8
    assign bsel    = i_field[10:8];
    assign ret     = goto_b && (bsel == dsp_seq_pkg::B_RET);
    assign iret    = goto_b && (bsel == dsp_seq_pkg::B_IRET);
    assign goto_pt = goto_b && (bsel == dsp_seq_pkg::B_GOTO_PT);
    assign call_pt = goto_b && (bsel == dsp_seq_pkg::B_CALL_PT);

    // Highest priority first
    always_comb begin
        if (ext_irq) begin
            pc_nxt = dsp_seq_pkg::IRQ_VEC;
        end else if (icall) begin
            pc_nxt = dsp_seq_pkg::ICALL_VEC;
        end else if (goto_ja || call_ja) begin
            pc_nxt = {pc[dsp_seq_pkg::ADDR_W-1:dsp_seq_pkg::FIELD_W], i_field}; // Same 4K page
        end else if (goto_pt || call_pt) begin
            pc_nxt = pt;
        end else if (ret) begin
            pc_nxt = pr;
        end else if (iret) begin
            pc_nxt = pi;
        end else if (pc_halt) begin
            pc_nxt = pc;
        end else begin
            pc_nxt = pc_inc;   // Sequential fetch, also spare subcodes
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
            pr <= '0;
            pi <= '0;
            pt <= '0;
        end else if (cen) begin
            if (shadow) pi <= pc_inc;            // Frozen during service
            if (call_ja || call_pt) pr <= pc_inc;
            if (post_inc) pt <= pt + i_ext;
            pc <= pc_nxt;
        end
    end

    assign rom_addr = pc;

endmodule

// File: dsp_seq_top.sv
//////////////////////////////////////////////////////////////////////
// Program sequencer top level
// Decoder, status flags and ROM address unit on the ROM port
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module dsp_seq_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cen,       // Only stall source
    input  logic                            ext_irq,
    input  logic [15:0]                     rom_data,  // Same-cycle ROM read
    output logic [dsp_seq_pkg::ADDR_W-1:0]  rom_addr,
    output logic                            in_irq
);

    logic                           goto_ja;
    logic                           call_ja;
    logic                           goto_b;
    logic                           icall;
    logic                           post_inc;
    logic                           pc_halt;
    logic                           irq_take;
    logic                           setf;
    logic                           con_result;
    logic                           shadow;
    logic [dsp_seq_pkg::FIELD_W-1:0] i_field;
    logic [dsp_seq_pkg::FLAG_W-1:0]  flag_val;
    logic [dsp_seq_pkg::COND_W-1:0]  cond;

    dsp_seq_decode dsp_seq_decode_inst (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .ext_irq    (ext_irq),
        .instr      (rom_data),     // ROM word read as the union
        .con_result (con_result),
        .goto_ja    (goto_ja),
        .call_ja    (call_ja),
        .goto_b     (goto_b),
        .icall      (icall),
        .post_inc   (post_inc),
        .pc_halt    (pc_halt),
        .irq_take   (irq_take),
        .setf       (setf),
        .i_field    (i_field),
        .flag_val   (flag_val),
        .cond       (cond),
        .shadow     (shadow),
        .in_irq     (in_irq)
    );

    dsp_seq_flags dsp_seq_flags_inst (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .setf       (setf),
        .flag_val   (flag_val),
        .cond       (cond),
        .con_result (con_result)
    );

    dsp_seq_rom_aau dsp_seq_rom_aau_inst (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .goto_ja    (goto_ja),
        .goto_b     (goto_b),
        .call_ja    (call_ja),
        .icall      (icall),
        .post_inc   (post_inc),
        .pc_halt    (pc_halt),
        .ext_irq    (irq_take),     // Only the accepted interrupt
        .i_field    (i_field),
        .shadow     (shadow),
        .rom_addr   (rom_addr)
    );

endmodule

// File: tb_dsp_seq.sv
//////////////////////////////////////////////////////////////////////
// Sequencer testbench with a combinational ROM model
// Clock, reset, check task, watchdog and six directed tests
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_dsp_seq;

    localparam int CLK_PERIOD = 40;
    localparam int N_TESTS    = 6;
    localparam int TEST_CYC   = 64;     // Cycle budget per test

    logic        clk;
    logic        rst;
    logic        cen;
    logic        ext_irq;
    logic [15:0] rom_data;
    logic [15:0] rom_addr;
    logic        in_irq;
    logic [15:0] rom [0:255];           // Program ROM model
    int          seed;

    dsp_seq_top dsp_seq_top_inst (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .ext_irq  (ext_irq),
        .rom_data (rom_data),
        .rom_addr (rom_addr),
        .in_irq   (in_irq)
    );

    // Same-cycle read, out of range gives NOP
    assign rom_data = (rom_addr < 16'd256) ? rom[rom_addr[7:0]] :
                      {dsp_seq_pkg::OP_NOP, 12'h000};

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(N_TESTS * TEST_CYC * CLK_PERIOD);
        $display("Timeout: the tests did not finish within the cycle budget");
        $display("ERRORS FOUND");
        $fatal(1);
    end

    // Bound checker counts its failures
    initial begin
        wait (dsp_seq_top_inst.dsp_seq_sva_inst.fail_cnt != 0);
        $display("A concurrent assertion on the sequencer top level failed");
        $display("ERRORS FOUND");
        $fatal(1);
    end

    function automatic logic [15:0] jump_word(logic [3:0] op, logic [11:0] field);
        return {op, field};
    endfunction

    function automatic logic [15:0] branch_word(logic [3:0] op, logic [2:0] bsel,
                                                logic [3:0] cnd);
        return {op, 1'b0, bsel, 4'h0, cnd};     // Reserved bits zero
    endfunction

    function automatic int rand_range(int lo, int span);
        return lo + int'($unsigned($random(seed)) % span);
    endfunction

    task automatic chk(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("ERR %s actual=%h expected=%h", name, act, exp);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    // NOP fill, low field bits carry the address
    task automatic clear_rom();
        for (int a = 0; a < 256; a++) begin
            rom[a] = {dsp_seq_pkg::OP_NOP, 4'h0, 8'(a)};
        end
    endtask

    task automatic reset_dut();
        @(posedge clk);
        rst     <= 1'b1;
        cen     <= 1'b1;
        ext_irq <= 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);                 // PC still 0 here
    endtask

    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            @(negedge clk);             // Outputs settled
        end
    endtask

    // One edge with old inputs, new values for the next one
    task automatic step_drive(input logic cen_v, input logic irq_v);
        @(posedge clk);
        cen     <= cen_v;
        ext_irq <= irq_v;
        @(negedge clk);
    endtask

    task automatic test_seq_fetch();
        clear_rom();
        reset_dut();
        chk("rom_addr", rom_addr, 0);
        chk("in_irq", in_irq, 0);
        for (int i = 1; i <= 5; i++) begin
            step(1);
            chk("rom_addr", rom_addr, i);
        end
        step_drive(1'b0, 1'b0);         // Last running edge
        chk("rom_addr", rom_addr, 6);
        step(4);
        chk("rom_addr", rom_addr, 6);
        step_drive(1'b1, 1'b0);         // Still stalled on this edge
        chk("rom_addr", rom_addr, 6);
        step(1);
        chk("rom_addr", rom_addr, 7);
    endtask

    task automatic test_goto_call();
        int t;
        int s;
        t = rand_range(16, 96);
        s = rand_range(128, 112);
        clear_rom();
        rom[0] = jump_word(dsp_seq_pkg::OP_GOTO_JA, 12'(t));
        rom[t] = jump_word(dsp_seq_pkg::OP_CALL_JA, 12'(s));
        rom[s] = branch_word(dsp_seq_pkg::OP_GOTO_B, dsp_seq_pkg::B_RET, 4'h0);
        reset_dut();
        step(1);
        chk("rom_addr", rom_addr, t);
        step(1);
        chk("rom_addr", rom_addr, s);
        step(1);
        chk("rom_addr", rom_addr, t + 1);   // Return lands after the call
    endtask

    task automatic test_table_ptr();
        int f;
        int g;
        int inc [4];
        f      = rand_range(32, 89);
        g      = f + rand_range(40, 61);
        inc[0] = rand_range(-40, 100);
        inc[1] = -rand_range(1, 40);    // Negative step
        inc[2] = rand_range(-40, 100);
        inc[3] = f - inc[0] - inc[1] - inc[2];
        clear_rom();
        for (int i = 0; i < 4; i++) begin
            rom[i] = jump_word(dsp_seq_pkg::OP_PT_ADD, 12'(inc[i]));
        end
        rom[4]     = branch_word(dsp_seq_pkg::OP_GOTO_B, dsp_seq_pkg::B_GOTO_PT, 4'h0);
        rom[f]     = jump_word(dsp_seq_pkg::OP_PT_ADD, 12'(g - f));
        rom[f + 1] = branch_word(dsp_seq_pkg::OP_GOTO_B, dsp_seq_pkg::B_CALL_PT, 4'h0);
        rom[g]     = branch_word(dsp_seq_pkg::OP_GOTO_B, dsp_seq_pkg::B_RET, 4'h0);
        reset_dut();
        for (int i = 1; i <= 4; i++) begin
            step(1);
            chk("rom_addr", rom_addr, i);
        end
        step(1);
        chk("rom_addr", rom_addr, f);       // PT holds the summed steps
        step(2);
        chk("rom_addr", rom_addr, g);
        step(1);
        chk("rom_addr", rom_addr, f + 2);
    endtask

    task automatic test_conditions();
        logic [3:0] fv;
        logic [3:0] code;
        logic       taken;
        int         p;
        int         pt_exp;
        fv = 4'($random(seed));
        clear_rom();
        rom[0] = jump_word(dsp_seq_pkg::OP_SETF, {8'h00, fv});
        p      = 1;
        pt_exp = 0;
        // Per code: PT_ADD to p+3, CGOTO_B, fall-through NOP
        // Codes 0..8, then always over an inverted pick
        for (int k = 0; k < 10; k++) begin
            code       = (k == 9) ? 4'hc : 4'(k);
            rom[p]     = jump_word(dsp_seq_pkg::OP_PT_ADD, 12'(p + 3 - pt_exp));
            rom[p + 1] = branch_word(dsp_seq_pkg::OP_CGOTO_B, dsp_seq_pkg::B_GOTO_PT, code);
            pt_exp     = p + 3;
            p         += 3;
        end
        reset_dut();
        step(1);
        p = 1;
        for (int k = 0; k < 10; k++) begin
            if (k >= 8) taken = 1'b1;       // Always codes, one picks a false flag
            else if (k < 4) taken = fv[k];
            else taken = !fv[k - 4];
            step(2);
            chk("rom_addr", rom_addr, taken ? p + 3 : p + 2);
            if (!taken) begin
                step(1);
                chk("rom_addr", rom_addr, p + 3);
            end
            p += 3;
        end
    endtask

    task automatic test_interrupts();
        clear_rom();
        rom[0]  = jump_word(dsp_seq_pkg::OP_GOTO_JA, 12'd60);   // Boot jump
        rom[61] = jump_word(dsp_seq_pkg::OP_HALT, 12'h000);
        rom[62] = jump_word(dsp_seq_pkg::OP_ICALL, 12'h000);
        rom[81] = branch_word(dsp_seq_pkg::OP_GOTO_B, dsp_seq_pkg::B_IRET, 4'h0);
        reset_dut();
        step(1);
        chk("rom_addr", rom_addr, 60);
        step(3);
        chk("rom_addr", rom_addr, 61);      // Halted
        rom[0] = jump_word(dsp_seq_pkg::OP_GOTO_JA, 12'd80);    // ISR entry at the vector
        step_drive(1'b1, 1'b1);
        chk("rom_addr", rom_addr, 61);
        step(1);
        chk("rom_addr", rom_addr, 0);
        chk("in_irq", in_irq, 1);
        step(1);                            // Request still high, ignored
        chk("rom_addr", rom_addr, 80);
        chk("in_irq", in_irq, 1);
        step_drive(1'b1, 1'b0);
        chk("rom_addr", rom_addr, 81);
        step(1);
        chk("rom_addr", rom_addr, 62);
        chk("in_irq", in_irq, 0);
        step(1);
        chk("rom_addr", rom_addr, 1);       // Software vector, no service state
        chk("in_irq", in_irq, 0);
    endtask

    task automatic test_unused();
        clear_rom();
        for (int i = 0; i < 7; i++) begin
            rom[i] = jump_word(dsp_seq_pkg::OP_HALT + 4'(i + 1), 12'(rand_range(0, 4096)));
        end
        for (int b = 4; b < 8; b++) begin
            rom[b + 3] = branch_word(dsp_seq_pkg::OP_GOTO_B, 3'(b), 4'($random(seed)));
        end
        reset_dut();
        for (int i = 1; i <= 11; i++) begin
            step(1);
            chk("rom_addr", rom_addr, i);
        end
    endtask

    initial begin
        seed    = 32'h76a2;
        rst     = 1'b1;
        cen     = 1'b1;
        ext_irq = 1'b0;
        test_seq_fetch();
        test_goto_call();
        test_table_ptr();
        test_conditions();
        test_interrupts();
        test_unused();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: tb_dsp_seq_sva.sv
//////////////////////////////////////////////////////////////////////
// Concurrent assertions on the sequencer ROM port
// Reset entry, cen stall, interrupt entry, bound into the top
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module dsp_seq_sva (
    input logic                            clk,
    input logic                            rst,
    input logic                            cen,
    input logic                            ext_irq,
    input logic [dsp_seq_pkg::ADDR_W-1:0]  rom_addr,
    input logic                            in_irq
);

    int fail_cnt = 0;   // Read by the testbench

    // First fetch after reset is address 0
    a_reset_entry: assert property (@(posedge clk) $fell(rst) |-> rom_addr == '0)
        else begin
            fail_cnt++;
            $error("rom_addr not 0 one cycle after reset release");
        end

    a_cen_hold: assert property (@(posedge clk) disable iff (rst)
        !cen |=> $stable(rom_addr) && $stable(in_irq))
        else begin
            fail_cnt++;
            $error("rom_addr or in_irq moved during a cen low cycle");
        end

    // Accepted request jumps to the vector and enters service
    a_irq_entry: assert property (@(posedge clk) disable iff (rst)
        cen && ext_irq && !in_irq |=> rom_addr == dsp_seq_pkg::IRQ_VEC && in_irq)
        else begin
            fail_cnt++;
            $error("interrupt entry missing vector or in_irq");
        end

endmodule

bind dsp_seq_top dsp_seq_sva dsp_seq_sva_inst (.*);
